// File: bench/golden_mux_vectors.txt
// hex words, one record per line
// 1 adr data: register write | 3 adr value: register read and expected value
// 2 port user len bytes: frame on a port | 0: end of records
3 0 0000
1 0 0000
2 0 1 6 10 11 12 13 14 15
2 1 0 4 30 31 32 33
2 0 0 8 40 41 42 43 44 45 46 47
1 0 0001
2 0 1 3 50 51 52
2 1 1 5 60 61 62 63 64
2 3 0 1 70
1 0 0003
1 0 0000
2 2 1 7 80 81 82 83 84 85 86
1 0 0006
3 0 0002
3 1 0003
3 2 0002
3 3 0001
3 4 0001
1 1 1234
3 1 0003
3 6 0000
0

// File: all.f
logic/axis_mux_pkg.sv
logic/axis_skid_buffer.sv
logic/axis_frame_mux.sv
logic/mux_ctrl_regs.sv
logic/axis_mux_top.sv
bench/tb_axis_mux.sv

// File: Bender.yml
package:
  name: axis_mux

sources:
  - logic/axis_mux_pkg.sv
  - logic/axis_skid_buffer.sv
  - logic/axis_frame_mux.sv
  - logic/mux_ctrl_regs.sv
  - logic/axis_mux_top.sv
  - target: test
    files:
      - bench/tb_axis_mux.sv

// File: bench/tb_axis_mux.sv
// Self-checking testbench for the four-input stream mux.
// Reads bench/golden_mux_vectors.txt relative to the project root, so the
// simulator must be started there. Frames on unselected ports stay queued
// until a later select write routes them.

`timescale 1ns/1ps
`default_nettype none

module tb_axis_mux
    import axis_mux_pkg::*;
();

    localparam int MEM_DEPTH  = 256;
    localparam int MAX_FRAMES = 32;

    logic                                 clk;
    logic                                 rst;
    wire  [NUM_PORTS-1:0][DATA_WIDTH-1:0] s_tdata;
    wire  [NUM_PORTS-1:0]                 s_tvalid;
    logic [NUM_PORTS-1:0]                 s_tready;
    wire  [NUM_PORTS-1:0]                 s_tlast;
    wire  [NUM_PORTS-1:0]                 s_tuser;
    logic [DATA_WIDTH-1:0]                m_tdata;
    logic                                 m_tvalid;
    logic                                 m_tready;
    logic                                 m_tlast;
    logic                                 m_tuser;
    logic                                 wb_cyc;
    logic                                 wb_stb;
    logic                                 wb_we;
    logic [WB_ADDR_WIDTH-1:0]             wb_adr;
    logic [WB_DATA_WIDTH-1:0]             wb_dat_w;
    logic [WB_DATA_WIDTH-1:0]             wb_dat_r;
    logic                                 wb_ack;

    // golden records, frames point into them by base word
    logic [15:0]           vec_mem [MEM_DEPTH];
    int                    frame_base [MAX_FRAMES];
    int                    frame_len [MAX_FRAMES];
    logic                  frame_user [MAX_FRAMES];
    int                    num_frames;
    int                    port_fifo [NUM_PORTS][MAX_FRAMES];
    int                    port_tail [NUM_PORTS];
    int                    routed_count [NUM_PORTS];
    int                    started_count [NUM_PORTS];
    int                    finished_count [NUM_PORTS];
    logic                  in_frame [NUM_PORTS];
    logic [DATA_WIDTH+1:0] exp_beats [$];
    port_sel_t             model_sel;
    int                    frames_out;
    int                    checks;
    int                    errors;
    int                    cycle_count;
    int                    cycle_limit;
    bit                    limit_ready;
    logic [15:0]           lfsr;
    logic                  bit_a;

    axis_mux_top dut (
        .clk(clk), .rst(rst),
        .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready),
        .s_tlast(s_tlast), .s_tuser(s_tuser),
        .m_tdata(m_tdata), .m_tvalid(m_tvalid), .m_tready(m_tready),
        .m_tlast(m_tlast), .m_tuser(m_tuser),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    function automatic int count_beats();
        int pc;
        int beats;
        pc = 0;
        beats = 0;
        while (pc < MEM_DEPTH && vec_mem[pc] != 0) begin
            if (vec_mem[pc] == 2) begin
                beats += vec_mem[pc+3];
                pc += 4 + vec_mem[pc+3];
            end else begin
                pc += 3;
            end
        end
        return beats;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    // single classic cycle, ack is seen at mid-cycle
    task automatic wb_transfer(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                               input logic [WB_DATA_WIDTH-1:0] wdata,
                               output logic [WB_DATA_WIDTH-1:0] rdata);
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // queued frames of the selected port join the expected output order
    task automatic route_pending(input port_sel_t p);
        int idx;
        int k;
        logic last;
        while (routed_count[p] < port_tail[p]) begin
            idx = port_fifo[p][routed_count[p]];
            for (k = 0; k < frame_len[idx]; k++) begin
                last = (k == frame_len[idx] - 1);
                exp_beats.push_back({frame_user[idx], last,
                                     vec_mem[frame_base[idx] + k][DATA_WIDTH-1:0]});
            end
            routed_count[p]++;
        end
    endtask

    task automatic wait_started(input port_sel_t p);
        while (started_count[p] < routed_count[p]) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_drained();
        while (frames_out < num_frames) begin
            @(negedge clk);
        end
    endtask

    for (genvar gp = 0; gp < NUM_PORTS; gp++) begin : g_src
        logic [DATA_WIDTH-1:0] data;
        logic                  valid;
        logic                  last;
        logic                  user;
        int                    head;

        assign s_tdata[gp]  = data;
        assign s_tvalid[gp] = valid;
        assign s_tlast[gp]  = last;
        assign s_tuser[gp]  = user;

        // each beat is held until the mux takes it
        task automatic send_frame(input int idx);
            int k;
            for (k = 0; k < frame_len[idx]; k++) begin
                @(posedge clk);
                #1;
                data  = vec_mem[frame_base[idx] + k][DATA_WIDTH-1:0];
                valid = 1'b1;
                last  = (k == frame_len[idx] - 1);
                user  = frame_user[idx];
                do begin
                    @(negedge clk);
                end while (!s_tready[gp]);
            end
            @(posedge clk);
            #1;
            valid = 1'b0;
            last  = 1'b0;
        endtask

        initial begin
            data  = '0;
            valid = 1'b0;
            last  = 1'b0;
            user  = 1'b0;
            head  = 0;
            forever begin
                while (head >= port_tail[gp]) begin
                    @(posedge clk);
                end
                send_frame(port_fifo[gp][head]);
                head++;
            end
        end
    end

    // input side: grants only for routed frames, count frame starts
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (s_tready[p] && routed_count[p] <= finished_count[p]) begin
                    errors++;
                    $display("port %0d got s_tready with no routed frame open at %0t", p, $time);
                end
                if (s_tvalid[p] && s_tready[p]) begin
                    if (!in_frame[p]) begin
                        started_count[p]++;
                    end
                    in_frame[p] = !s_tlast[p];
                    if (s_tlast[p]) begin
                        finished_count[p]++;
                    end
                end
            end
        end
    end

    always @(negedge clk) begin : output_monitor
        logic [DATA_WIDTH+1:0] beat;
        if (!rst && m_tvalid && m_tready) begin
            if (exp_beats.size() == 0) begin
                errors++;
                $display("output beat 0x%0h arrived with no frame expected at %0t", m_tdata, $time);
            end else begin
                beat = exp_beats.pop_front();
                check_value("m_tdata", beat[DATA_WIDTH-1:0], m_tdata);
                check_value("m_tlast", beat[DATA_WIDTH], m_tlast);
                check_value("m_tuser", beat[DATA_WIDTH+1], m_tuser);
            end
            if (m_tlast) begin
                frames_out++;
            end
        end
    end

    // random sink, two LFSR bits per cycle for about 75 percent ready
    initial begin
        lfsr = 16'd45;
        m_tready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            bit_a = lfsr[0];
            lfsr = lfsr_next(lfsr);
            m_tready = bit_a | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d of %0d frames out", cycle_count, frames_out,
                 num_frames);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main_sequence
        int pc;
        int op;
        int adr;
        int dat;
        int p;
        logic [WB_DATA_WIDTH-1:0] rdata;
        bit done;

        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        model_sel = '0;
        for (pc = 0; pc < MEM_DEPTH; pc++) begin
            vec_mem[pc] = '0;
        end
        for (p = 0; p < NUM_PORTS; p++) begin
            in_frame[p] = 1'b0;
        end
        $readmemh("bench/golden_mux_vectors.txt", vec_mem);
        cycle_limit = 40 * count_beats() + 200;
        limit_ready = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("s_tready", '0, s_tready);
        check_value("m_tvalid", '0, m_tvalid);
        check_value("wb_ack", '0, wb_ack);

        pc = 0;
        done = 1'b0;
        while (!done && pc < MEM_DEPTH) begin
            op = vec_mem[pc];
            adr = vec_mem[pc+1];
            dat = vec_mem[pc+2];
            case (op)
                0: done = 1'b1;
                1: begin
                    // old port has no unstarted routed frames, so the new
                    // select decides every later frame start
                    if (adr == REG_SELECT) begin
                        model_sel = port_sel_t'(dat);
                        route_pending(model_sel);
                    end
                    wb_transfer(1'b1, adr, dat, rdata);
                    wait_started(model_sel);
                    pc += 3;
                end
                2: begin
                    frame_user[num_frames] = vec_mem[pc+2][0];
                    frame_len[num_frames]  = vec_mem[pc+3];
                    frame_base[num_frames] = pc + 4;
                    port_fifo[adr][port_tail[adr]] = num_frames;
                    port_tail[adr]++;
                    num_frames++;
                    if (adr == model_sel) begin
                        route_pending(model_sel);
                        wait_started(model_sel);
                    end
                    pc += 4 + vec_mem[pc+3];
                end
                3: begin
                    wait_drained();
                    repeat (2) @(posedge clk);
                    wb_transfer(1'b0, adr, '0, rdata);
                    check_value("wb_dat_r", dat, rdata);
                    pc += 3;
                end
                default: begin
                    errors++;
                    $display("golden file has unknown record type %0h at word %0d", op, pc);
                    done = 1'b1;
                end
            endcase
        end

        wait_drained();
        repeat (8) @(negedge clk);
        check_value("exp_beats.size", 0, exp_beats.size());
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/axis_mux_top.sv
// Four-input stream mux with registered output and Wishbone control.
// Input to output latency varies with back-pressure; watch m_tvalid.
// Select changes take effect at the next frame start.

`timescale 1ns/1ps
`default_nettype none

module axis_mux_top
    import axis_mux_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] s_tdata,
    input  logic [NUM_PORTS-1:0]                 s_tvalid,
    output logic [NUM_PORTS-1:0]                 s_tready,
    input  logic [NUM_PORTS-1:0]                 s_tlast,
    input  logic [NUM_PORTS-1:0]                 s_tuser,

    output logic [DATA_WIDTH-1:0]                m_tdata,
    output logic                                 m_tvalid,
    input  logic                                 m_tready,
    output logic                                 m_tlast,
    output logic                                 m_tuser,

    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [WB_ADDR_WIDTH-1:0]             wb_adr,
    input  logic [WB_DATA_WIDTH-1:0]             wb_dat_w,
    output logic [WB_DATA_WIDTH-1:0]             wb_dat_r,
    output logic                                 wb_ack
);

    logic [DATA_WIDTH-1:0] mux_tdata;
    logic                  mux_tvalid;
    logic                  mux_tlast;
    logic                  mux_tuser;
    logic                  buf_ready_early;

    port_sel_t             select;
    logic                  frame_done;
    port_sel_t             done_port;

    axis_frame_mux u_mux (
        .clk             (clk),
        .rst             (rst),
        .s_tdata         (s_tdata),
        .s_tvalid        (s_tvalid),
        .s_tready        (s_tready),
        .s_tlast         (s_tlast),
        .s_tuser         (s_tuser),
        .select          (select),
        .buf_ready_early (buf_ready_early),
        .mux_tdata       (mux_tdata),
        .mux_tvalid      (mux_tvalid),
        .mux_tlast       (mux_tlast),
        .mux_tuser       (mux_tuser),
        .frame_done      (frame_done),
        .done_port       (done_port)
    );

    axis_skid_buffer u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_tdata    (mux_tdata),
        .in_tvalid   (mux_tvalid),
        .in_tlast    (mux_tlast),
        .in_tuser    (mux_tuser),
        .ready_early (buf_ready_early),
        .m_tdata     (m_tdata),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser)
    );

    mux_ctrl_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .frame_done (frame_done),
        .done_port  (done_port),
        .select     (select)
    );

endmodule

`default_nettype wire

// File: logic/mux_ctrl_regs.sv
// Wishbone classic slave with the select register and frame counters.
// Single-beat cycles only; ack comes one cycle after the strobe.
// Counters are read-only and wrap. Unmapped reads return zero and
// unmapped or counter writes are acked and dropped.

`timescale 1ns/1ps
`default_nettype none

module mux_ctrl_regs
    import axis_mux_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [WB_DATA_WIDTH-1:0] wb_dat_w,
    output logic [WB_DATA_WIDTH-1:0] wb_dat_r,
    output logic                     wb_ack,

    input  logic                     frame_done,
    input  port_sel_t                done_port,

    output port_sel_t                select
);

    port_sel_t                            select_reg;
    logic [NUM_PORTS-1:0][CNT_WIDTH-1:0]  frame_cnt;
    logic                                 ack_reg;
    logic [WB_DATA_WIDTH-1:0]             rdata_reg;

    logic                                 req;
    logic                                 hit_select;
    logic                                 hit_count;
    logic [WB_ADDR_WIDTH-1:0]             cnt_offset;
    port_sel_t                            cnt_idx;
    logic [WB_DATA_WIDTH-1:0]             read_data;

    // new request, suppressed in the ack cycle so each strobe acks once
    assign req = wb_cyc & wb_stb & ~ack_reg;

    assign cnt_offset = wb_adr - REG_COUNT_BASE;
    assign cnt_idx    = port_sel_t'(cnt_offset);
    assign hit_select = (wb_adr == REG_SELECT);
    assign hit_count  = (wb_adr >= REG_COUNT_BASE) &&
                        (cnt_offset < WB_ADDR_WIDTH'(NUM_PORTS));

    always_comb begin
        read_data = '0;
        if (hit_select) begin
            read_data = WB_DATA_WIDTH'(select_reg);
        end else if (hit_count) begin
            read_data = WB_DATA_WIDTH'(frame_cnt[cnt_idx]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_reg    <= 1'b0;
            select_reg <= '0;
            frame_cnt  <= '0;
        end else begin
            ack_reg <= req;
            if (req & wb_we & hit_select) begin
                select_reg <= wb_dat_w[SEL_WIDTH-1:0];
            end
            // one completed frame per pulse, wraps at full scale
            if (frame_done) begin
                frame_cnt[done_port] <= frame_cnt[done_port] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdata_reg <= read_data;
        end
    end

    assign wb_ack   = ack_reg;
    assign wb_dat_r = rdata_reg;
    assign select   = select_reg;

    // ack only answers a strobe seen on the previous edge
    a_ack_follows_stb: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

`default_nettype wire

// File: logic/axis_frame_mux.sv
// Frame-aware 4:1 stream selector.
// select is sampled only between frames; a new value waits for the
// next frame start. One frame is in flight at a time, and a new frame
// cannot start on the same edge that the previous one ends.
// frame_done pulses one cycle after the last beat transfers.

`timescale 1ns/1ps
`default_nettype none

module axis_frame_mux
    import axis_mux_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] s_tdata,
    input  logic [NUM_PORTS-1:0]                 s_tvalid,
    output logic [NUM_PORTS-1:0]                 s_tready,
    input  logic [NUM_PORTS-1:0]                 s_tlast,
    input  logic [NUM_PORTS-1:0]                 s_tuser,

    input  port_sel_t                            select,
    input  logic                                 buf_ready_early,

    output logic [DATA_WIDTH-1:0]                mux_tdata,
    output logic                                 mux_tvalid,
    output logic                                 mux_tlast,
    output logic                                 mux_tuser,

    output logic                                 frame_done,
    output port_sel_t                            done_port
);

    port_sel_t             sel_reg;
    port_sel_t             sel_next;
    logic                  frame_reg;
    logic                  frame_next;
    logic [NUM_PORTS-1:0]  ready_reg;
    logic [NUM_PORTS-1:0]  ready_next;

    logic                  done_reg;
    port_sel_t             done_port_reg;

    logic                  start_valid;
    logic [DATA_WIDTH-1:0] cur_tdata;
    logic                  cur_tvalid;
    logic                  cur_tready;
    logic                  cur_tlast;
    logic                  cur_tuser;
    logic                  cur_xfer;

    // port asked for by software, looked at only while idle
    assign start_valid = s_tvalid[select];

    // latched port for the frame in flight
    assign cur_tdata  = s_tdata[sel_reg];
    assign cur_tvalid = s_tvalid[sel_reg];
    assign cur_tready = ready_reg[sel_reg];
    assign cur_tlast  = s_tlast[sel_reg];
    assign cur_tuser  = s_tuser[sel_reg];

    assign cur_xfer = frame_reg & cur_tvalid & cur_tready;

    always_comb begin
        sel_next   = sel_reg;
        frame_next = frame_reg;
        ready_next = '0;

        if (frame_reg) begin
            // frame closes when its last beat moves
            if (cur_xfer) begin
                frame_next = ~cur_tlast;
            end
        end else if (start_valid) begin
            frame_next = 1'b1;
            sel_next   = select;
        end

        // ready only ever goes to the latched port
        ready_next[sel_next] = buf_ready_early & frame_next;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_reg       <= '0;
            frame_reg     <= 1'b0;
            ready_reg     <= '0;
            done_reg      <= 1'b0;
            done_port_reg <= '0;
        end else begin
            sel_reg   <= sel_next;
            frame_reg <= frame_next;
            ready_reg <= ready_next;
            done_reg  <= cur_xfer & cur_tlast;
            if (cur_xfer & cur_tlast) begin
                done_port_reg <= sel_reg;
            end
        end
    end

    assign s_tready = ready_reg;

    // only beats that really moved are handed to the buffer
    assign mux_tdata  = cur_tdata;
    assign mux_tvalid = cur_xfer;
    assign mux_tlast  = cur_tlast;
    assign mux_tuser  = cur_tuser;

    assign frame_done = done_reg;
    assign done_port  = done_port_reg;

    // never grant two sources at once
    a_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(s_tready));

endmodule

`default_nettype wire

// File: logic/axis_skid_buffer.sv
// Two-entry output slice for the mux output stream.
// Upstream must only present a valid beat one cycle after ready_early
// was high; the buffer takes every valid beat it sees.
// No combinational path from m_tready to ready_early's consumers' regs.

`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer
    import axis_mux_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic                  in_tvalid,
    input  logic                  in_tlast,
    input  logic                  in_tuser,
    output logic                  ready_early,

    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tvalid,
    input  logic                  m_tready,
    output logic                  m_tlast,
    output logic                  m_tuser
);

    logic                  ready_reg;

    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_valid;
    logic                  out_last;
    logic                  out_user;

    logic [DATA_WIDTH-1:0] tmp_data;
    logic                  tmp_valid;
    logic                  tmp_last;
    logic                  tmp_user;

    logic                  load_out;
    logic                  load_tmp;
    logic                  shift_tmp;

    // accept next cycle if the sink drains, both slots are empty,
    // or the temp slot is free and will not be filled this cycle
    assign ready_early = m_tready | (~tmp_valid & ~out_valid) | (~tmp_valid & ~in_tvalid);

    // input lands in output reg when it is free or draining
    assign load_out  = ready_reg & (m_tready | ~out_valid);
    // output stalled, so park the beat in temp
    assign load_tmp  = ready_reg & ~m_tready & out_valid;
    // upstream paused, move temp forward
    assign shift_tmp = ~ready_reg & m_tready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg <= 1'b0;
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (load_out) begin
                out_valid <= in_tvalid;
            end else if (shift_tmp) begin
                out_valid <= tmp_valid;
            end
            if (load_tmp) begin
                tmp_valid <= in_tvalid;
            end else if (shift_tmp) begin
                tmp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data <= in_tdata;
            out_last <= in_tlast;
            out_user <= in_tuser;
        end else if (shift_tmp) begin
            out_data <= tmp_data;
            out_last <= tmp_last;
            out_user <= tmp_user;
        end
        if (load_tmp) begin
            tmp_data <= in_tdata;
            tmp_last <= in_tlast;
            tmp_user <= in_tuser;
        end
    end

    assign m_tdata  = out_data;
    assign m_tvalid = out_valid;
    assign m_tlast  = out_last;
    assign m_tuser  = out_user;

    // a stalled beat must not change under the sink
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (m_tvalid && !m_tready) |=> $stable({m_tdata, m_tlast, m_tuser}));

endmodule

`default_nettype wire

// File: logic/axis_mux_pkg.sv
// Shared sizes and register map for the four-input stream mux.
// Only the widths below are supported; the control block decodes a
// three-bit word address space.

`default_nettype none

package axis_mux_pkg;

    // stream side
    localparam int DATA_WIDTH = 8;
    localparam int NUM_PORTS  = 4;
    localparam int SEL_WIDTH  = 2;

    typedef logic [SEL_WIDTH-1:0] port_sel_t;

    // control port
    localparam int WB_ADDR_WIDTH = 3;
    localparam int WB_DATA_WIDTH = 16;
    localparam int CNT_WIDTH     = 16;

    // word addresses, counter n sits at REG_COUNT_BASE + n
    localparam logic [WB_ADDR_WIDTH-1:0] REG_SELECT     = 3'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_COUNT_BASE = 3'd1;

endpackage

`default_nettype wire
